// ==== logic/gpio_apb_regs.sv ====
// APB register slave for the GPIO bank, holding the output control registers and input readback
`timescale 1ns/100ps

module gpio_apb_regs (
	input  logic                                inclock_wire,
	input  logic                                rst_n,
	input  logic                                psel,
	input  logic                                penable,
	input  logic                                pwrite,
	input  logic [gpio_pkg::apb_addr_width-1:0] paddr,
	input  logic [gpio_pkg::apb_data_width-1:0] pwdata,
	output logic [gpio_pkg::apb_data_width-1:0] prdata,
	output logic                                pready,
	output logic                                pslverr,
	input  gpio_pkg::pin_vec_t                  in_sync,
	output gpio_pkg::pin_vec_t                  out_data,
	output gpio_pkg::pin_vec_t                  oe_mask,
	output gpio_pkg::pin_vec_t                  invert_mask,
	output gpio_pkg::pin_vec_t                  od_mask
);

	import gpio_pkg::*;

	logic       access;
	logic       wr_en;
	logic       sel_data_out;
	logic       sel_oe;
	logic       sel_invert;
	logic       sel_open_drain;
	logic       sel_data_in;
	logic       sel_out_setclr;
	logic       addr_mapped;
	out_wdata_u wdata;
	pin_vec_t   setclr_data;

	// zero wait states, every access completes in one cycle
	assign pready = 1'b1;

	assign access = psel & penable;
	assign wr_en  = access & pwrite;

	assign sel_data_out   = (paddr == addr_data_out);
	assign sel_oe         = (paddr == addr_oe);
	assign sel_invert     = (paddr == addr_invert);
	assign sel_open_drain = (paddr == addr_open_drain);
	assign sel_data_in    = (paddr == addr_data_in);
	assign sel_out_setclr = (paddr == addr_out_setclr);

	assign addr_mapped = sel_data_out | sel_oe | sel_invert | sel_open_drain |
		sel_data_in | sel_out_setclr;

	// writes to the read-only input register are refused as well as unmapped offsets
	assign pslverr = access & (~addr_mapped | (pwrite & sel_data_in));

	assign wdata.raw = pwdata;

	// clear first so that a pin named in both masks ends up set
	assign setclr_data = (out_data & ~wdata.setclr.clr_mask) | wdata.setclr.set_mask;

	always_ff @(posedge inclock_wire)
	begin
		if (!rst_n)
		begin
			out_data    <= '0;
			oe_mask     <= '0;
			invert_mask <= '0;
			od_mask     <= '0;
		end
		else if (wr_en)
		begin
			if (sel_data_out)
				out_data <= wdata.raw[num_pins-1:0];
			else if (sel_out_setclr)
				out_data <= setclr_data;

			if (sel_oe)
				oe_mask <= wdata.raw[num_pins-1:0];

			if (sel_invert)
				invert_mask <= wdata.raw[num_pins-1:0];

			if (sel_open_drain)
				od_mask <= wdata.raw[num_pins-1:0];
		end
	end

	// the set/clear port and unmapped offsets read back as zero
	always_comb
	begin
		prdata = '0;
		if (sel_data_out)
			prdata[num_pins-1:0] = out_data;
		else if (sel_oe)
			prdata[num_pins-1:0] = oe_mask;
		else if (sel_invert)
			prdata[num_pins-1:0] = invert_mask;
		else if (sel_open_drain)
			prdata[num_pins-1:0] = od_mask;
		else if (sel_data_in)
			prdata[num_pins-1:0] = in_sync;
	end

	// an error response belongs to an access phase that followed a setup phase
	ap_err_in_access: assert property (
		@(posedge inclock_wire) disable iff (!rst_n)
		pslverr |-> (psel && penable && $past(psel && !penable))
	);

	// the master never raises penable without a selected slave
	ap_enable_needs_sel: assert property (
		@(posedge inclock_wire) disable iff (!rst_n)
		penable |-> psel
	);

endmodule

// ==== logic/gpio_in_path.sv ====
// GPIO input path with a two-flop synchronizer and a capture register per pin
`timescale 1ns/100ps

module gpio_in_path (
	input  logic               inclock_wire,
	input  logic               rst_n,
	input  gpio_pkg::pin_vec_t pad_in,
	output gpio_pkg::pin_vec_t in_sync
);

	import gpio_pkg::*;

	pin_vec_t sync_meta;
	pin_vec_t sync_stable;

	// pads are asynchronous to the bus clock, so the first flop may go metastable
	always_ff @(posedge inclock_wire)
	begin
		if (!rst_n)
		begin
			sync_meta   <= '0;
			sync_stable <= '0;
			in_sync     <= '0;
		end
		else
		begin
			sync_meta   <= pad_in;
			sync_stable <= sync_meta;
			in_sync     <= sync_stable;
		end
	end

	// readback starts from zero whatever the pads were doing during reset
	ap_sync_clear: assert property (
		@(posedge inclock_wire)
		!rst_n |=> (in_sync == '0)
	);

endmodule

// ==== logic/gpio_out_path.sv ====
// GPIO output path applying inversion and open-drain, then registering pad data and enable
`timescale 1ns/100ps

module gpio_out_path (
	input  logic               inclock_wire,
	input  logic               rst_n,
	input  gpio_pkg::pin_vec_t out_data,
	input  gpio_pkg::pin_vec_t oe_mask,
	input  gpio_pkg::pin_vec_t invert_mask,
	input  gpio_pkg::pin_vec_t od_mask,
	output gpio_pkg::pin_vec_t pad_out,
	output gpio_pkg::pin_vec_t pad_oe
);

	import gpio_pkg::*;

	pin_vec_t drive_lvl;
	pin_vec_t pad_out_d;
	pin_vec_t pad_oe_d;

	// level the pin should show on the wire
	assign drive_lvl = out_data ^ invert_mask;

	// an open-drain pin only ever pulls low, a high level releases the pad
	assign pad_out_d = drive_lvl & ~od_mask;
	assign pad_oe_d  = oe_mask & ~(od_mask & drive_lvl);

	// one register per pin for data and for enable, as in the single-register pad mode
	always_ff @(posedge inclock_wire)
	begin
		if (!rst_n)
		begin
			pad_out <= '0;
			pad_oe  <= '0;
		end
		else
		begin
			pad_out <= pad_out_d;
			pad_oe  <= pad_oe_d;
		end
	end

	// pins that were enabled open-drain on the previous edge never drive a high level
	ap_od_no_high: assert property (
		@(posedge inclock_wire) disable iff (!rst_n)
		(pad_oe & pad_out & $past(od_mask & oe_mask)) == '0
	);

endmodule

// ==== logic/gpio_pkg.sv ====
// GPIO bank shared definitions: pin count, APB register map and the output write-word views

package gpio_pkg;

	// the register layout holds one bit per pin in the low half of a word
	localparam int num_pins = 16;

	localparam int apb_addr_width = 8;
	localparam int apb_data_width = 32;

	// register offsets, all word aligned
	localparam logic [apb_addr_width-1:0] addr_data_out   = 8'h00;
	localparam logic [apb_addr_width-1:0] addr_oe         = 8'h04;
	localparam logic [apb_addr_width-1:0] addr_invert     = 8'h08;
	localparam logic [apb_addr_width-1:0] addr_open_drain = 8'h0C;
	localparam logic [apb_addr_width-1:0] addr_data_in    = 8'h10;
	localparam logic [apb_addr_width-1:0] addr_out_setclr = 8'h14;

	typedef logic [num_pins-1:0] pin_vec_t;

	// a write word is either taken whole or split into set and clear masks
	// for the set/clear port, where set wins for a pin named in both
	typedef union packed
	{
		logic [apb_data_width-1:0] raw;
		struct packed
		{
			pin_vec_t set_mask;
			pin_vec_t clr_mask;
		} setclr;
	} out_wdata_u;

endpackage

// ==== logic/gpio_top.sv ====
// GPIO bank top level joining the APB register slave to the output and input pad paths
`timescale 1ns/100ps

module gpio_top (
	input  logic                                inclock_wire,
	input  logic                                rst_n,
	input  logic                                psel,
	input  logic                                penable,
	input  logic                                pwrite,
	input  logic [gpio_pkg::apb_addr_width-1:0] paddr,
	input  logic [gpio_pkg::apb_data_width-1:0] pwdata,
	output logic [gpio_pkg::apb_data_width-1:0] prdata,
	output logic                                pready,
	output logic                                pslverr,
	output gpio_pkg::pin_vec_t                  pad_out,
	output gpio_pkg::pin_vec_t                  pad_oe,
	input  gpio_pkg::pin_vec_t                  pad_in
);

	import gpio_pkg::*;

	pin_vec_t out_data;
	pin_vec_t oe_mask;
	pin_vec_t invert_mask;
	pin_vec_t od_mask;
	pin_vec_t in_sync;

	gpio_apb_regs u_regs (
		.inclock_wire (inclock_wire),
		.rst_n        (rst_n),
		.psel         (psel),
		.penable      (penable),
		.pwrite       (pwrite),
		.paddr        (paddr),
		.pwdata       (pwdata),
		.prdata       (prdata),
		.pready       (pready),
		.pslverr      (pslverr),
		.in_sync      (in_sync),
		.out_data     (out_data),
		.oe_mask      (oe_mask),
		.invert_mask  (invert_mask),
		.od_mask      (od_mask)
	);

	// pads change two edges after the write access that set them
	gpio_out_path u_out_path (
		.inclock_wire (inclock_wire),
		.rst_n        (rst_n),
		.out_data     (out_data),
		.oe_mask      (oe_mask),
		.invert_mask  (invert_mask),
		.od_mask      (od_mask),
		.pad_out      (pad_out),
		.pad_oe       (pad_oe)
	);

	gpio_in_path u_in_path (
		.inclock_wire (inclock_wire),
		.rst_n        (rst_n),
		.pad_in       (pad_in),
		.in_sync      (in_sync)
	);

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# builds the GPIO bank testbench with Verilator and runs it, the exit status gives pass or fail

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	-f sim.f \
	--top-module gpio_tb \
	-o gpio_sim \
	&& ./obj_dir/gpio_sim \
	|| { echo "simulation did not complete successfully"; exit 1; }

exit 0

// ==== sim.f ====
logic/gpio_pkg.sv
logic/gpio_apb_regs.sv
logic/gpio_out_path.sv
logic/gpio_in_path.sv
logic/gpio_top.sv
sim/gpio_tb.sv

// ==== sim/gpio_tb.sv ====
// GPIO bank testbench driving APB accesses and pad inputs, checked by assertions against a model
`timescale 1ns/100ps

module gpio_tb;

	import gpio_pkg::*;

	localparam int reset_cycles    = 10;
	localparam int num_tests       = 6;
	localparam int watchdog_cycles = num_tests * 200 + reset_cycles;
	localparam int loops           = 8;

	logic                      inclock_wire;
	logic                      rst_n;
	logic                      psel;
	logic                      penable;
	logic                      pwrite;
	logic [apb_addr_width-1:0] paddr;
	logic [apb_data_width-1:0] pwdata;
	logic [apb_data_width-1:0] prdata;
	logic                      pready;
	logic                      pslverr;
	pin_vec_t                  pad_out;
	pin_vec_t                  pad_oe;
	pin_vec_t                  pad_in;

	// reference copy of the control registers
	pin_vec_t model_data_out;
	pin_vec_t model_oe;
	pin_vec_t model_invert;
	pin_vec_t model_od;

	pin_vec_t                  pad_out_next;
	pin_vec_t                  pad_oe_next;
	pin_vec_t                  pad_out_expect = '0;
	pin_vec_t                  pad_oe_expect  = '0;
	pin_vec_t                  in_stage1      = '0;
	pin_vec_t                  in_stage2      = '0;
	pin_vec_t                  in_expect      = '0;
	logic [apb_data_width-1:0] rd_expect;
	logic                      err_expect;

	gpio_top uut (
		.inclock_wire (inclock_wire),
		.rst_n        (rst_n),
		.psel         (psel),
		.penable      (penable),
		.pwrite       (pwrite),
		.paddr        (paddr),
		.pwdata       (pwdata),
		.prdata       (prdata),
		.pready       (pready),
		.pslverr      (pslverr),
		.pad_out      (pad_out),
		.pad_oe       (pad_oe),
		.pad_in       (pad_in)
	);

	initial
	begin
		inclock_wire = 1'b0;
		forever #5 inclock_wire = ~inclock_wire;
	end

	function automatic pin_vec_t driven_out(input pin_vec_t data, input pin_vec_t inv,
		input pin_vec_t od);
		pin_vec_t result;
		result = '0;
		for (int i = 0; i < num_pins; i++)
			result[i] = od[i] ? 1'b0 : (data[i] ^ inv[i]);
		return result;
	endfunction

	// an open-drain pin is only enabled while it pulls low
	function automatic pin_vec_t driven_enable(input pin_vec_t data, input pin_vec_t inv,
		input pin_vec_t oe, input pin_vec_t od);
		pin_vec_t result;
		result = '0;
		for (int i = 0; i < num_pins; i++)
			result[i] = od[i] ? (oe[i] & ~(data[i] ^ inv[i])) : oe[i];
		return result;
	endfunction

	function automatic logic [apb_data_width-1:0] read_value(
		input logic [apb_addr_width-1:0] addr,
		input pin_vec_t data, input pin_vec_t oe, input pin_vec_t inv, input pin_vec_t od,
		input pin_vec_t in_val);
		case (addr)
			addr_data_out:   return 32'(data);
			addr_oe:         return 32'(oe);
			addr_invert:     return 32'(inv);
			addr_open_drain: return 32'(od);
			addr_data_in:    return 32'(in_val);
			default:         return '0;
		endcase
	endfunction

	function automatic logic error_expected(input logic [apb_addr_width-1:0] addr,
		input logic write);
		logic mapped;
		mapped = addr inside {addr_data_out, addr_oe, addr_invert, addr_open_drain,
			addr_data_in, addr_out_setclr};
		return !mapped || (write && addr == addr_data_in);
	endfunction

	assign pad_out_next = driven_out(model_data_out, model_invert, model_od);
	assign pad_oe_next  = driven_enable(model_data_out, model_invert, model_oe, model_od);
	assign rd_expect    = read_value(paddr, model_data_out, model_oe, model_invert, model_od,
		in_expect);
	assign err_expect   = error_expected(paddr, pwrite);

	// pads lag the register model by one edge and inputs reach readback after three edges
	always @(posedge inclock_wire)
	begin
		pad_out_expect <= pad_out_next;
		pad_oe_expect  <= pad_oe_next;
		in_stage1      <= pad_in;
		in_stage2      <= in_stage1;
		in_expect      <= in_stage2;
	end

	task automatic report_mismatch(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("CHECK FAILED at %0d ns: %s expected 0x%0h, got 0x%0h", $time, name,
			expected, actual);
		$display("*** FAILED ***");
		$fatal(1, "stopped at the first mismatch");
	endtask

	ap_pad_out: assert property (@(posedge inclock_wire) disable iff (!rst_n)
		pad_out == pad_out_expect)
	else report_mismatch("pad_out", 32'($sampled(pad_out_expect)), 32'($sampled(pad_out)));

	ap_pad_oe: assert property (@(posedge inclock_wire) disable iff (!rst_n)
		pad_oe == pad_oe_expect)
	else report_mismatch("pad_oe", 32'($sampled(pad_oe_expect)), 32'($sampled(pad_oe)));

	ap_prdata: assert property (@(posedge inclock_wire) disable iff (!rst_n)
		(psel && penable && !pwrite) |-> (prdata == rd_expect))
	else report_mismatch("prdata", $sampled(rd_expect), $sampled(prdata));

	ap_pslverr: assert property (@(posedge inclock_wire) disable iff (!rst_n)
		pslverr == (psel && penable && err_expect))
	else report_mismatch("pslverr", 32'($sampled(psel && penable && err_expect)),
		32'($sampled(pslverr)));

	ap_pready: assert property (@(posedge inclock_wire) disable iff (!rst_n)
		pready == 1'b1)
	else report_mismatch("pready", 32'd1, 32'($sampled(pready)));

	task automatic update_model(input logic [apb_addr_width-1:0] addr,
		input logic [apb_data_width-1:0] data);
		case (addr)
			addr_data_out:   model_data_out = data[num_pins-1:0];
			addr_oe:         model_oe = data[num_pins-1:0];
			addr_invert:     model_invert = data[num_pins-1:0];
			addr_open_drain: model_od = data[num_pins-1:0];
			addr_out_setclr:
			begin
				for (int i = 0; i < num_pins; i++)
				begin
					if (data[num_pins+i])
						model_data_out[i] = 1'b1;
					else if (data[i])
						model_data_out[i] = 1'b0;
				end
			end
			default:
			begin
			end
		endcase
	endtask

	task automatic apb_write(input logic [apb_addr_width-1:0] addr,
		input logic [apb_data_width-1:0] data);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = 1'b1;
		paddr   = addr;
		pwdata  = data;
		@(posedge inclock_wire);
		#1;
		penable = 1'b1;
		@(posedge inclock_wire);
		#1;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		update_model(addr, data);
	endtask

	task automatic apb_read(input logic [apb_addr_width-1:0] addr);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = addr;
		@(posedge inclock_wire);
		#1;
		penable = 1'b1;
		@(posedge inclock_wire);
		#1;
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic wait_edges(input int n);
		repeat (n) @(posedge inclock_wire);
		#1;
	endtask

	task automatic read_all_registers();
		apb_read(addr_data_out);
		apb_read(addr_oe);
		apb_read(addr_invert);
		apb_read(addr_open_drain);
		apb_read(addr_data_in);
		apb_read(addr_out_setclr);
	endtask

	initial
	begin
		repeat (watchdog_cycles) @(posedge inclock_wire);
		$display("timeout: the tests did not finish within %0d cycles", watchdog_cycles);
		$display("*** FAILED ***");
		$fatal(1, "watchdog expired");
	end

	initial
	begin
		rst_n          = 1'b0;
		psel           = 1'b0;
		penable        = 1'b0;
		pwrite         = 1'b0;
		paddr          = '0;
		pwdata         = '0;
		pad_in         = '0;
		model_data_out = '0;
		model_oe       = '0;
		model_invert   = '0;
		model_od       = '0;
		void'($urandom(32'he06e));
		repeat (reset_cycles) @(posedge inclock_wire);
		#1;
		rst_n = 1'b1;

		// everything reads zero straight out of reset
		read_all_registers();

		for (int n = 0; n < loops; n++)
		begin
			apb_write(addr_data_out, $urandom());
			apb_write(addr_oe, $urandom());
			apb_read(addr_data_out);
			apb_read(addr_oe);
			wait_edges(2);
		end

		// set wins where both masks name a pin
		apb_write(addr_out_setclr, 32'hffff_ffff);
		for (int n = 0; n < loops; n++)
		begin
			apb_write(addr_out_setclr, $urandom());
			apb_read(addr_data_out);
			apb_read(addr_out_setclr);
		end

		for (int n = 0; n < loops; n++)
		begin
			apb_write(addr_invert, $urandom());
			apb_write(addr_open_drain, $urandom());
			apb_write(addr_data_out, $urandom());
			apb_write(addr_oe, $urandom());
			apb_read(addr_invert);
			apb_read(addr_open_drain);
			wait_edges(2);
		end

		for (int n = 0; n < loops; n++)
		begin
			pad_in = pin_vec_t'($urandom());
			wait_edges(3);
			apb_read(addr_data_in);
		end

		apb_write(addr_data_in, $urandom());
		apb_write(8'h18, $urandom());
		apb_read(8'h02);
		apb_read(8'hfc);
		for (int n = 0; n < loops; n++)
		begin
			apb_write(8'(24 + ($urandom() % 232)), $urandom());
			apb_read(8'(24 + ($urandom() % 232)));
		end
		read_all_registers();
		wait_edges(2);

		$display("*** PASSED ***");
		$finish;
	end

endmodule
